// File: verilog/uart_rx_pkg.sv
package uart_rx_pkg;

    // ======================================================================
    // bit timing, 866 cycles per bit is about 115200 baud at 100 MHz
    // ======================================================================
    localparam int baud_one_bit      = 866;
    localparam int baud_one_half_bit = 1301;   // start edge to middle of data bit 0
    localparam int baud_cnt_width    = 11;

    // ======================================================================
    // frame format
    // ======================================================================
    localparam int data_bits     = 8;          // 8N1, no parity
    localparam int bit_cnt_width = 4;

    // shared select for the baud counter and the bit counter
    typedef enum logic [1:0] {
        cnt_clear = 2'b00,
        cnt_hold  = 2'b01,
        cnt_inc   = 2'b11
    } counter_op_t;

    // compare point of the baud counter
    typedef enum logic {
        target_one_half = 1'b0,
        target_one      = 1'b1
    } baud_target_t;

    typedef enum logic [1:0] {
        rx_idle  = 2'b00,
        rx_start = 2'b01,
        rx_data  = 2'b10,
        rx_stop  = 2'b11
    } rx_state_t;

    typedef logic [data_bits-1:0] rx_byte_t;

endpackage

// File: verilog/uart_rx_shift_reg.sv
`timescale 1ns/1ps

module uart_rx_shift_reg (
    input  logic                  clk,
    input  logic                  reset_b,
    input  logic                  rx_bit,
    input  logic                  shift_rx_sel,
    output uart_rx_pkg::rx_byte_t rx_data
);
    import uart_rx_pkg::*;

    // serial data arrives LSB first, so each new bit enters at the top
    // and the first bit has walked down to bit 0 after the eighth shift
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            rx_data <= '0;
        end
        else if (shift_rx_sel)
        begin
            rx_data <= {rx_bit, rx_data[data_bits-1:1]};
        end
    end

endmodule

// File: verilog/baud_mid_compare.sv
`timescale 1ns/1ps

module baud_mid_compare (
    input  logic                      clk,
    input  logic                      reset_b,
    input  uart_rx_pkg::counter_op_t  baud_counter_sel,
    input  uart_rx_pkg::baud_target_t baud_mid_compare_sel,
    output logic                      baud_mid_compare_val
);
    import uart_rx_pkg::*;

    // the count starts at zero, so each target is the cycle count minus one
    localparam logic [baud_cnt_width-1:0] one_bit_last      =
        baud_cnt_width'(baud_one_bit - 1);
    localparam logic [baud_cnt_width-1:0] one_half_bit_last =
        baud_cnt_width'(baud_one_half_bit - 1);

    logic [baud_cnt_width-1:0] baud_count;
    logic [baud_cnt_width-1:0] compare_target;

    // ======================================================================
    // bit-time counter
    // ======================================================================
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            baud_count <= '0;
        end
        else
        begin
            case (baud_counter_sel)
                cnt_clear: baud_count <= '0;
                cnt_inc:   baud_count <= baud_count + 1'b1;
                default:   baud_count <= baud_count;   // hold
            endcase
        end
    end

    // ======================================================================
    // compare against the selected sample point
    // ======================================================================
    always_comb
    begin
        if (baud_mid_compare_sel == target_one)
            compare_target = one_bit_last;
        else
            compare_target = one_half_bit_last;   // first sample after the start edge
    end

    assign baud_mid_compare_val = (baud_count == compare_target);

endmodule

// File: verilog/bit_counter.sv
`timescale 1ns/1ps

module bit_counter (
    input  logic                     clk,
    input  logic                     reset_b,
    input  uart_rx_pkg::counter_op_t bit_counter_sel,
    output logic                     bit_counter_compare_val
);
    import uart_rx_pkg::*;

    localparam logic [bit_cnt_width-1:0] last_count = bit_cnt_width'(data_bits);

    logic [bit_cnt_width-1:0] bit_count;

    // counts data bits taken into the shift register
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            bit_count <= '0;
        end
        else
        begin
            case (bit_counter_sel)
                cnt_clear: bit_count <= '0;
                cnt_inc:   bit_count <= bit_count + 1'b1;
                default:   bit_count <= bit_count;
            endcase
        end
    end

    // high once all data bits of the frame are in
    assign bit_counter_compare_val = (bit_count == last_count);

endmodule

// File: verilog/uart_rx_datapath.sv
`timescale 1ns/1ps

module uart_rx_datapath (
    input  logic                      clk,
    input  logic                      reset_b,
    input  logic                      uart_rx_in,
    input  logic                      shift_rx_sel,
    input  uart_rx_pkg::baud_target_t baud_mid_compare_sel,
    input  uart_rx_pkg::counter_op_t  baud_counter_sel,
    input  uart_rx_pkg::counter_op_t  bit_counter_sel,
    output logic                      rx_sync,
    output logic                      baud_mid_compare_val,
    output logic                      bit_counter_compare_val,
    output uart_rx_pkg::rx_byte_t     uart_rx_data_out
);

    logic rx_meta;   // first synchronizer stage, not used anywhere else

    // ======================================================================
    // two-flop synchronizer, resets to the idle line level
    // ======================================================================
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= uart_rx_in;
            rx_sync <= rx_meta;
        end
    end

    // ======================================================================
    // datapath blocks
    // ======================================================================
    uart_rx_shift_reg ursr (
        .clk          (clk),
        .reset_b      (reset_b),
        .rx_bit       (rx_sync),
        .shift_rx_sel (shift_rx_sel),
        .rx_data      (uart_rx_data_out)
    );

    baud_mid_compare bmc (
        .clk                  (clk),
        .reset_b              (reset_b),
        .baud_counter_sel     (baud_counter_sel),
        .baud_mid_compare_sel (baud_mid_compare_sel),
        .baud_mid_compare_val (baud_mid_compare_val)
    );

    bit_counter bc (
        .clk                     (clk),
        .reset_b                 (reset_b),
        .bit_counter_sel         (bit_counter_sel),
        .bit_counter_compare_val (bit_counter_compare_val)
    );

endmodule

// File: verilog/uart_rx_control.sv
`timescale 1ns/1ps

module uart_rx_control (
    input  logic                      clk,
    input  logic                      reset_b,
    input  logic                      rx_sync,
    input  logic                      baud_mid_compare_val,
    input  logic                      bit_counter_compare_val,
    output logic                      shift_rx_sel,
    output uart_rx_pkg::baud_target_t baud_mid_compare_sel,
    output uart_rx_pkg::counter_op_t  baud_counter_sel,
    output uart_rx_pkg::counter_op_t  bit_counter_sel,
    output logic                      data_valid,
    output logic                      framing_error
);
    import uart_rx_pkg::*;

    rx_state_t state;
    rx_state_t state_next;
    logic      rx_prev;        // line value one cycle back
    logic      start_edge;
    logic      stop_sample;

    // a start bit needs a falling edge, so a line held low after a
    // framing error is not taken as a new frame
    assign start_edge  = rx_prev && !rx_sync;
    assign stop_sample = (state == rx_stop) && baud_mid_compare_val;

    // ======================================================================
    // state register and line history
    // ======================================================================
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            state   <= rx_idle;
            rx_prev <= 1'b1;
        end
        else
        begin
            state   <= state_next;
            rx_prev <= rx_sync;
        end
    end

    // ======================================================================
    // next state and datapath selects
    // ======================================================================
    always_comb
    begin
        state_next           = state;
        shift_rx_sel         = 1'b0;
        baud_mid_compare_sel = target_one;
        baud_counter_sel     = cnt_inc;
        bit_counter_sel      = cnt_hold;

        case (state)
            rx_idle:
            begin
                baud_counter_sel = cnt_clear;
                bit_counter_sel  = cnt_clear;
                if (start_edge)
                    state_next = rx_start;
            end

            rx_start:
            begin
                baud_mid_compare_sel = target_one_half;
                if (baud_mid_compare_val)
                begin
                    // middle of data bit 0
                    shift_rx_sel     = 1'b1;
                    baud_counter_sel = cnt_clear;
                    bit_counter_sel  = cnt_inc;
                    state_next       = rx_data;
                end
            end

            rx_data:
            begin
                if (bit_counter_compare_val)
                begin
                    state_next = rx_stop;   // baud count keeps running into the stop bit
                end
                else if (baud_mid_compare_val)
                begin
                    shift_rx_sel     = 1'b1;
                    baud_counter_sel = cnt_clear;
                    bit_counter_sel  = cnt_inc;
                end
            end

            rx_stop:
            begin
                if (baud_mid_compare_val)
                    state_next = rx_idle;
            end

            default:
            begin
                state_next = rx_idle;
            end
        endcase
    end

    // ======================================================================
    // result pulses, one cycle after the stop bit sample
    // ======================================================================
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            data_valid    <= 1'b0;
            framing_error <= 1'b0;
        end
        else
        begin
            data_valid    <= stop_sample && rx_sync;
            framing_error <= stop_sample && !rx_sync;   // stop bit read as 0
        end
    end

endmodule

// File: verilog/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
    input  logic                  clk,
    input  logic                  reset_b,
    input  logic                  rx_in,
    output uart_rx_pkg::rx_byte_t rx_data,
    output logic                  data_valid,
    output logic                  framing_error
);
    import uart_rx_pkg::*;

    logic         rx_sync;
    logic         shift_rx_sel;
    logic         baud_mid_compare_val;
    logic         bit_counter_compare_val;
    baud_target_t baud_mid_compare_sel;
    counter_op_t  baud_counter_sel;
    counter_op_t  bit_counter_sel;

    uart_rx_control u_control (
        .clk                     (clk),
        .reset_b                 (reset_b),
        .rx_sync                 (rx_sync),
        .baud_mid_compare_val    (baud_mid_compare_val),
        .bit_counter_compare_val (bit_counter_compare_val),
        .shift_rx_sel            (shift_rx_sel),
        .baud_mid_compare_sel    (baud_mid_compare_sel),
        .baud_counter_sel        (baud_counter_sel),
        .bit_counter_sel         (bit_counter_sel),
        .data_valid              (data_valid),
        .framing_error           (framing_error)
    );

    uart_rx_datapath u_datapath (
        .clk                     (clk),
        .reset_b                 (reset_b),
        .uart_rx_in              (rx_in),
        .shift_rx_sel            (shift_rx_sel),
        .baud_mid_compare_sel    (baud_mid_compare_sel),
        .baud_counter_sel        (baud_counter_sel),
        .bit_counter_sel         (bit_counter_sel),
        .rx_sync                 (rx_sync),
        .baud_mid_compare_val    (baud_mid_compare_val),
        .bit_counter_compare_val (bit_counter_compare_val),
        .uart_rx_data_out        (rx_data)
    );

endmodule

// File: sim/uart_rx_tb.sv
`timescale 1ns/1ps

module uart_rx_tb;
    import uart_rx_pkg::*;

    localparam int clk_half_period = 2;
    localparam int timeout_cycles  = 12 * baud_one_bit;
    localparam int random_rows     = 20;

    typedef struct packed {
        rx_byte_t   data;
        logic       stop;   // 0 gives a framing error
        logic [1:0] gap;    // idle bit times after the frame
    } frame_row_t;

    logic       clk;
    logic       reset_b;
    logic       rx_in;
    rx_byte_t   rx_data;
    logic       data_valid;
    logic       framing_error;

    frame_row_t rows[$];
    int         seed;
    int         valid_pulses;
    int         error_pulses;
    logic       got_valid;
    logic       got_error;
    rx_byte_t   got_byte;

    uart_rx DUT (
        .clk           (clk),
        .reset_b       (reset_b),
        .rx_in         (rx_in),
        .rx_data       (rx_data),
        .data_valid    (data_valid),
        .framing_error (framing_error)
    );

    initial
    begin
        clk = 1'b0;
        forever #clk_half_period clk = ~clk;
    end

    // every pulse is counted, so a second or a long pulse shows up per frame
    always @(negedge clk)
    begin
        if (data_valid)
            valid_pulses++;
        if (framing_error)
            error_pulses++;
    end

    // ======================================================================
    // compare tasks
    // ======================================================================
    task automatic stop_with_failure();
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_byte(input rx_byte_t actual, input rx_byte_t expected,
                              input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s, got 8'h%02h, expected 8'h%02h",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected)
        begin
            $display("mismatch at %0t ns: %s, got %b, expected %b",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual != expected)
        begin
            $display("mismatch at %0t ns: %s, got %0d pulses, expected %0d",
                     $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    // ======================================================================
    // serial driver and result wait
    // ======================================================================
    task automatic drive_bit(input logic value);
        @(posedge clk);
        rx_in <= value;
        repeat (baud_one_bit - 1) @(posedge clk);   // held for one full bit time
    endtask

    task automatic send_frame(input frame_row_t row);
        int i;
        drive_bit(1'b0);
        for (i = 0; i < data_bits; i++)
            drive_bit(row.data[i]);   // LSB first
        drive_bit(row.stop);
        for (i = 0; i < int'(row.gap); i++)
            drive_bit(1'b1);
    endtask

    task automatic wait_for_result(output logic valid, output logic error,
                                   output rx_byte_t data);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        valid  = 1'b0;
        error  = 1'b0;
        data   = '0;
        while (!seen && cycles < timeout_cycles)
        begin
            @(negedge clk);
            cycles++;
            if (data_valid || framing_error)
            begin
                seen  = 1'b1;
                valid = data_valid;
                error = framing_error;
                data  = rx_data;
            end
        end
        if (!seen)
        begin
            $display("no data_valid or framing_error within timeout");
            stop_with_failure();
        end
    endtask

    function automatic void add_row(input rx_byte_t data, input logic stop,
                                    input logic [1:0] gap);
        frame_row_t row;
        row.data = data;
        row.stop = stop;
        row.gap  = gap;
        rows.push_back(row);
    endfunction

    // ======================================================================
    // stimulus table and main sequence
    // ======================================================================
    initial
    begin
        int r;
        int valid_before;
        int error_before;
        int rand_byte;
        int rand_gap;

        reset_b      = 1'b0;
        rx_in        = 1'b1;
        seed         = 32'h348e_4848;
        valid_pulses = 0;
        error_pulses = 0;

        add_row(8'h00, 1'b1, 2'd1);
        add_row(8'hff, 1'b1, 2'd0);
        add_row(8'h55, 1'b1, 2'd2);
        add_row(8'ha5, 1'b1, 2'd0);
        add_row(8'h01, 1'b1, 2'd3);
        add_row(8'h3c, 1'b0, 2'd1);   // bad stop bit, the gap gives the next start edge
        add_row(8'h80, 1'b1, 2'd0);
        add_row(8'h12, 1'b1, 2'd0);   // back to back from here
        add_row(8'h34, 1'b1, 2'd0);
        add_row(8'h56, 1'b1, 2'd0);
        add_row(8'h78, 1'b1, 2'd1);
        for (r = 0; r < random_rows; r++)
        begin
            rand_byte = $random(seed);
            rand_gap  = {$random(seed)} % 4;
            add_row(rx_byte_t'(rand_byte), 1'b1, 2'(rand_gap));
        end

        repeat (4) @(posedge clk);
        reset_b <= 1'b1;

        // idle line after reset gives no pulses and a cleared byte
        repeat (3 * baud_one_bit)
        begin
            @(negedge clk);
            check_byte(rx_data, 8'h00, "rx_data after reset");
            check_flag(data_valid, 1'b0, "data_valid on idle line");
            check_flag(framing_error, 1'b0, "framing_error on idle line");
        end

        for (r = 0; r < rows.size(); r++)
        begin
            valid_before = valid_pulses;
            error_before = error_pulses;
            fork
                send_frame(rows[r]);
                wait_for_result(got_valid, got_error, got_byte);
            join
            check_flag(got_valid, rows[r].stop, $sformatf("frame %0d data_valid", r));
            check_flag(got_error, !rows[r].stop, $sformatf("frame %0d framing_error", r));
            if (rows[r].stop)
                check_byte(got_byte, rows[r].data, $sformatf("frame %0d rx_data", r));
            check_count(valid_pulses - valid_before, rows[r].stop ? 1 : 0,
                        $sformatf("frame %0d data_valid count", r));
            check_count(error_pulses - error_before, rows[r].stop ? 0 : 1,
                        $sformatf("frame %0d framing_error count", r));
        end

        $display("Done: no errors");
        $finish;
    end

endmodule

// File: files.f
verilog/uart_rx_pkg.sv
verilog/uart_rx_shift_reg.sv
verilog/baud_mid_compare.sv
verilog/bit_counter.sv
verilog/uart_rx_datapath.sv
verilog/uart_rx_control.sv
verilog/uart_rx.sv
sim/uart_rx_tb.sv

// File: Makefile
# Verilator build for the UART receiver testbench
# any variable can be overridden, e.g. make check LOG=other.log

VERILATOR ?= verilator
TOP       ?= uart_rx_tb
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f

.PHONY: all compile run check clean

all: check

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the log is kept even when the model stops with an error
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)

check: run
	@if grep -q "Done: no errors" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
